// ==== src/mdu_pkg.sv ====
package mdu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  rob_id_t;

    typedef enum logic [1:0] {
        mdu_mul,
        mdu_mulhu,
        mdu_divu,
        mdu_remu
    } mdu_op_t;

    // reference result of one operation
    // a zero divisor makes divu all ones and remu the dividend
    function automatic word_t mdu_eval(mdu_op_t op, word_t a, word_t b);
        logic [63:0] prod;
        prod = {32'b0, a} * {32'b0, b};
        case (op)
            mdu_mul:   return prod[31:0];
            mdu_mulhu: return prod[63:32];
            mdu_divu:  return (b == '0) ? '1 : a / b;
            default:   return (b == '0) ? a : a % b;
        endcase
    endfunction

endpackage

// ==== src/iq_entry.sv ====
`timescale 1ns/1ps

module iq_entry #(
    parameter int CDB_COUNT  = 2,
    parameter int WKUP_COUNT = 2
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                init_i,
    input  logic                                select_i,
    input  mdu_pkg::mdu_op_t                    op_i,
    input  mdu_pkg::rob_id_t                    wreg_id_i,
    input  mdu_pkg::word_t   [1:0]              src_data_i,
    input  mdu_pkg::rob_id_t [1:0]              src_tag_i,
    input  logic             [1:0]              src_ready_i,
    input  logic             [CDB_COUNT-1:0]    cdb_valid_i,
    input  mdu_pkg::rob_id_t [CDB_COUNT-1:0]    cdb_reg_id_i,
    input  mdu_pkg::word_t   [CDB_COUNT-1:0]    cdb_data_i,
    input  logic             [WKUP_COUNT-1:0]   wkup_valid_i,
    input  mdu_pkg::rob_id_t [WKUP_COUNT-1:0]   wkup_reg_id_i,
    input  mdu_pkg::word_t   [WKUP_COUNT-1:0]   wkup_data_i,
    output logic                                ready_o,
    output mdu_pkg::mdu_op_t                    op_o,
    output mdu_pkg::rob_id_t                    wreg_id_o,
    output mdu_pkg::word_t   [1:0]              data_o,
    output logic [1:0][WKUP_COUNT-1:0]          wkup_hit_o
);
    import mdu_pkg::*;

    logic                           occ_q;
    mdu_op_t                        op_q;
    rob_id_t                        wreg_q;
    word_t   [1:0]                  data_q;
    word_t   [1:0]                  data_n;
    word_t   [1:0]                  fwd_data;
    rob_id_t [1:0]                  tag_q;
    rob_id_t [1:0]                  cur_tag;
    logic    [1:0]                  rdy_q;
    logic    [1:0]                  rdy_n;
    logic    [1:0]                  cur_rdy;
    logic    [1:0]                  cdb_hit;
    logic    [1:0][WKUP_COUNT-1:0]  hit_q;
    logic    [1:0][WKUP_COUNT-1:0]  wm;

    // --------------------
    // operand snooping
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            // a hit recorded last cycle means the data is on the port now
            fwd_data[k] = data_q[k];
            for (int j = 0; j < WKUP_COUNT; j++) begin
                if (hit_q[k][j]) begin
                    fwd_data[k] = wkup_data_i[j];
                end
            end

            // fresh dispatch is snooped in the cycle it is written
            cur_tag[k] = init_i ? src_tag_i[k] : tag_q[k];
            cur_rdy[k] = init_i ? src_ready_i[k] : rdy_q[k];
            data_n[k]  = init_i ? src_data_i[k] : fwd_data[k];

            cdb_hit[k] = 1'b0;
            for (int j = 0; j < CDB_COUNT; j++) begin
                if (!cur_rdy[k] && cdb_valid_i[j] && cdb_reg_id_i[j] == cur_tag[k]) begin
                    cdb_hit[k] = 1'b1;
                    data_n[k]  = cdb_data_i[j];
                end
            end

            for (int j = 0; j < WKUP_COUNT; j++) begin
                wm[k][j] = !cur_rdy[k] && !cdb_hit[k] && wkup_valid_i[j]
                           && wkup_reg_id_i[j] == cur_tag[k];
            end

            rdy_n[k] = cur_rdy[k] || cdb_hit[k] || (|wm[k]);
        end
    end

    // an announced tag already counts as ready
    // the bypass stage fills in its data
    assign ready_o    = occ_q && (rdy_q[0] || |wm[0]) && (rdy_q[1] || |wm[1]);
    assign wkup_hit_o = wm;
    assign data_o     = fwd_data;
    assign op_o       = op_q;
    assign wreg_id_o  = wreg_q;

    // --------------------
    // slot state
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occ_q <= 1'b0;
        end else if (flush_i) begin
            occ_q <= 1'b0;
        end else if (init_i) begin
            occ_q <= 1'b1;
        end else if (select_i) begin
            occ_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            op_q   <= op_i;
            wreg_q <= wreg_id_i;
        end
        data_q <= data_n;
        tag_q  <= cur_tag;
        rdy_q  <= rdy_n;
        hit_q  <= wm;
    end

    // head select and tail write never land on the same slot
    assert property (@(posedge clk) disable iff (!rst_n_i) !(init_i && select_i));

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass #(
    parameter int WKUP_COUNT = 2
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              flush_i,
    input  logic                              load_i,
    input  mdu_pkg::word_t [1:0]              data_i,
    input  logic [1:0][WKUP_COUNT-1:0]        wkup_hit_i,
    input  mdu_pkg::word_t [WKUP_COUNT-1:0]   wkup_data_i,
    output mdu_pkg::word_t [1:0]              data_o
);
    import mdu_pkg::*;

    word_t [1:0]                data_q;
    logic  [1:0][WKUP_COUNT-1:0] hit_q;

    // woken operands take the port data one cycle after the tag
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            data_o[k] = data_q[k];
            for (int j = 0; j < WKUP_COUNT; j++) begin
                if (hit_q[k][j]) begin
                    data_o[k] = wkup_data_i[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_q <= '0;
        end else if (flush_i || !load_i) begin
            hit_q <= '0;
        end else begin
            hit_q <= wkup_hit_i;
        end
    end

    // keep the substituted value while the unit stalls
    always_ff @(posedge clk) begin
        if (load_i) begin
            data_q <= data_i;
        end else begin
            data_q <= data_o;
        end
    end

endmodule

// ==== src/mdu_unit.sv ====
`timescale 1ns/1ps

module mdu_unit (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              flush_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  mdu_pkg::mdu_op_t  op_i,
    input  mdu_pkg::rob_id_t  reg_id_i,
    input  mdu_pkg::word_t    a_i,
    input  mdu_pkg::word_t    b_i,
    output logic              valid_o,
    input  logic              ready_i,
    output mdu_pkg::word_t    data_o,
    output mdu_pkg::rob_id_t  reg_id_o
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_div,
        st_done
    } state_t;

    state_t       state_q;
    logic [5:0]   step_q;
    logic         accept;
    logic         is_mul;
    logic [63:0]  prod;
    logic [32:0]  trial;
    logic [32:0]  diff;
    mdu_op_t      op_q;
    rob_id_t      tag_q;
    word_t        a_q;
    word_t        b_q;
    word_t        quo_q;
    word_t        rem_q;
    word_t        res_q;

    assign ready_o  = (state_q == st_idle);
    assign valid_o  = (state_q == st_done);
    assign accept   = valid_i && ready_o;
    assign is_mul   = (op_i == mdu_mul) || (op_i == mdu_mulhu);
    assign data_o   = res_q;
    assign reg_id_o = tag_q;

    // one full product serves both mul and mulhu
    assign prod = {32'b0, a_i} * {32'b0, b_i};

    // restoring step with dividend bits shifted in from the quotient register
    assign trial = {rem_q, quo_q[31]};
    assign diff  = trial - {1'b0, b_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= st_idle;
            step_q  <= '0;
        end else if (flush_i) begin
            state_q <= st_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (accept) begin
                        state_q <= is_mul ? st_done : st_div;
                    end
                    step_q <= '0;
                end
                st_div: begin
                    // 32 steps plus the result write
                    if (step_q == 6'd32) begin
                        state_q <= st_done;
                    end
                    step_q <= step_q + 6'd1;
                end
                default: begin
                    if (ready_i) begin
                        state_q <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= op_i;
            tag_q <= reg_id_i;
            a_q   <= a_i;
            b_q   <= b_i;
            quo_q <= a_i;
            rem_q <= '0;
            if (is_mul) begin
                res_q <= (op_i == mdu_mul) ? prod[31:0] : prod[63:32];
            end
        end else if (state_q == st_div) begin
            if (step_q == 6'd32) begin
                // zero divisor falls out as all ones and the dividend
                res_q <= (op_q == mdu_divu) ? quo_q : rem_q;
            end else begin
                quo_q <= {quo_q[30:0], !diff[32]};
                rem_q <= diff[32] ? trial[31:0] : diff[31:0];
            end
        end
    end

    // held result does not move under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
        valid_o && !ready_i |=> $stable(data_o) && $stable(reg_id_o));

    // both datapaths agree with the reference function
    assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> data_o == mdu_eval(op_q, a_q, b_q));

endmodule

// ==== src/mdu_iq.sv ====
`timescale 1ns/1ps

module mdu_iq #(
    parameter int IQ_SIZE    = 4,
    parameter int CDB_COUNT  = 2,
    parameter int WKUP_COUNT = 2
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic             [1:0]              dispatch_valid_i,
    input  mdu_pkg::mdu_op_t [1:0]              dispatch_op_i,
    input  mdu_pkg::rob_id_t [1:0]              dispatch_wreg_id_i,
    input  mdu_pkg::word_t   [1:0][1:0]         src_data_i,
    input  mdu_pkg::rob_id_t [1:0][1:0]         src_tag_i,
    input  logic             [1:0][1:0]         src_ready_i,
    output logic                                entry_ready_o,
    input  logic             [CDB_COUNT-1:0]    cdb_valid_i,
    input  mdu_pkg::rob_id_t [CDB_COUNT-1:0]    cdb_reg_id_i,
    input  mdu_pkg::word_t   [CDB_COUNT-1:0]    cdb_data_i,
    input  logic             [WKUP_COUNT-1:0]   wkup_valid_i,
    input  mdu_pkg::rob_id_t [WKUP_COUNT-1:0]   wkup_reg_id_i,
    input  mdu_pkg::word_t   [WKUP_COUNT-1:0]   wkup_data_i,
    input  logic                                fifo_ready_i,
    output logic                                entry_valid_o,
    output mdu_pkg::word_t                      result_data_o,
    output mdu_pkg::rob_id_t                    result_reg_id_o
);
    import mdu_pkg::*;

    localparam int PTR_W = $clog2(IQ_SIZE);

    logic [PTR_W-1:0]             head_q;
    logic [PTR_W-1:0]             tail_q;
    logic [PTR_W-1:0]             tail_p1;
    logic [PTR_W:0]               free_q;
    logic [PTR_W:0]               free_n;
    logic [1:0]                   disp_cnt;
    logic                         head_ready;
    logic                         iss_ready;
    logic                         issue;
    logic                         iss_valid_q;
    logic                         mdu_ready;
    mdu_op_t                      iss_op_q;
    rob_id_t                      iss_tag_q;
    word_t [1:0]                  iss_data;
    logic [IQ_SIZE-1:0]           ent_ready;
    logic [IQ_SIZE-1:0]           ent_init;
    logic [IQ_SIZE-1:0]           ent_sel;
    logic [IQ_SIZE-1:0]           ent_src;
    mdu_op_t                      ent_op [IQ_SIZE];
    rob_id_t                      ent_tag [IQ_SIZE];
    word_t [1:0]                  ent_data [IQ_SIZE];
    logic [1:0][WKUP_COUNT-1:0]   ent_hit [IQ_SIZE];

    // --------------------
    // pointers and free count
    assign disp_cnt = dispatch_valid_i[0] + dispatch_valid_i[1];
    assign tail_p1  = tail_q + 1'b1;
    assign free_n   = free_q - disp_cnt + issue;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= (PTR_W + 1)'(IQ_SIZE);
            entry_ready_o <= 1'b1;
            iss_valid_q   <= 1'b0;
        end else if (flush_i) begin
            head_q        <= '0;
            tail_q        <= '0;
            free_q        <= (PTR_W + 1)'(IQ_SIZE);
            entry_ready_o <= 1'b1;
            iss_valid_q   <= 1'b0;
        end else begin
            head_q        <= head_q + PTR_W'(issue);
            tail_q        <= tail_q + PTR_W'(disp_cnt);
            free_q        <= free_n;
            // room for a full pair next cycle
            entry_ready_o <= (free_n >= 2);
            if (iss_ready) begin
                iss_valid_q <= issue;
            end
        end
    end

    // --------------------
    // slot steering
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            ent_sel[i]  = issue && (PTR_W'(i) == head_q);
            ent_init[i] = 1'b0;
            ent_src[i]  = 1'b1;
            if (PTR_W'(i) == tail_q) begin
                // older valid slot goes first
                ent_init[i] = |dispatch_valid_i;
                ent_src[i]  = !dispatch_valid_i[0];
            end else if (PTR_W'(i) == tail_p1) begin
                ent_init[i] = &dispatch_valid_i;
            end
        end
    end

    for (genvar i = 0; i < IQ_SIZE; i++) begin : g_entry
        iq_entry #(
            .CDB_COUNT (CDB_COUNT),
            .WKUP_COUNT(WKUP_COUNT)
        ) u_entry (
            .clk,
            .rst_n_i,
            .flush_i,
            .init_i       (ent_init[i]),
            .select_i     (ent_sel[i]),
            .op_i         (dispatch_op_i[ent_src[i]]),
            .wreg_id_i    (dispatch_wreg_id_i[ent_src[i]]),
            .src_data_i   (src_data_i[ent_src[i]]),
            .src_tag_i    (src_tag_i[ent_src[i]]),
            .src_ready_i  (src_ready_i[ent_src[i]]),
            .cdb_valid_i,
            .cdb_reg_id_i,
            .cdb_data_i,
            .wkup_valid_i,
            .wkup_reg_id_i,
            .wkup_data_i,
            .ready_o      (ent_ready[i]),
            .op_o         (ent_op[i]),
            .wreg_id_o    (ent_tag[i]),
            .data_o       (ent_data[i]),
            .wkup_hit_o   (ent_hit[i])
        );
    end

    // --------------------
    // in-order issue from the head
    assign head_ready = ent_ready[head_q];
    assign iss_ready  = !iss_valid_q || mdu_ready;
    assign issue      = head_ready && iss_ready;

    always_ff @(posedge clk) begin
        if (issue) begin
            iss_op_q  <= ent_op[head_q];
            iss_tag_q <= ent_tag[head_q];
        end
    end

    operand_bypass #(
        .WKUP_COUNT(WKUP_COUNT)
    ) u_bypass (
        .clk,
        .rst_n_i,
        .flush_i,
        .load_i     (issue),
        .data_i     (ent_data[head_q]),
        .wkup_hit_i (ent_hit[head_q]),
        .wkup_data_i,
        .data_o     (iss_data)
    );

    mdu_unit u_mdu (
        .clk,
        .rst_n_i,
        .flush_i,
        .valid_i  (iss_valid_q),
        .ready_o  (mdu_ready),
        .op_i     (iss_op_q),
        .reg_id_i (iss_tag_q),
        .a_i      (iss_data[0]),
        .b_i      (iss_data[1]),
        .valid_o  (entry_valid_o),
        .ready_i  (fifo_ready_i),
        .data_o   (result_data_o),
        .reg_id_o (result_reg_id_o)
    );

    // dispatcher honours the registered two-slot level
    assert property (@(posedge clk) disable iff (!rst_n_i)
        |dispatch_valid_i |-> entry_ready_o);

    assert property (@(posedge clk) disable iff (!rst_n_i) free_q <= IQ_SIZE);

endmodule

// ==== src/mdu_issue_top.sv ====
`timescale 1ns/1ps

module mdu_issue_top #(
    parameter int IQ_SIZE    = 4,
    parameter int CDB_COUNT  = 2,
    parameter int WKUP_COUNT = 2
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic             [1:0]              dispatch_valid_i,
    input  mdu_pkg::mdu_op_t [1:0]              dispatch_op_i,
    input  mdu_pkg::rob_id_t [1:0]              dispatch_wreg_id_i,
    input  mdu_pkg::word_t   [1:0][1:0]         src_data_i,
    input  mdu_pkg::rob_id_t [1:0][1:0]         src_tag_i,
    input  logic             [1:0][1:0]         src_ready_i,
    output logic                                entry_ready_o,
    input  logic             [CDB_COUNT-1:0]    cdb_valid_i,
    input  mdu_pkg::rob_id_t [CDB_COUNT-1:0]    cdb_reg_id_i,
    input  mdu_pkg::word_t   [CDB_COUNT-1:0]    cdb_data_i,
    input  logic             [WKUP_COUNT-1:0]   wkup_valid_i,
    input  mdu_pkg::rob_id_t [WKUP_COUNT-1:0]   wkup_reg_id_i,
    input  mdu_pkg::word_t   [WKUP_COUNT-1:0]   wkup_data_i,
    input  logic                                fifo_ready_i,
    output logic                                entry_valid_o,
    output mdu_pkg::word_t                      result_data_o,
    output mdu_pkg::rob_id_t                    result_reg_id_o
);

    // single multiply/divide issue queue
    mdu_iq #(
        .IQ_SIZE   (IQ_SIZE),
        .CDB_COUNT (CDB_COUNT),
        .WKUP_COUNT(WKUP_COUNT)
    ) u_iq (
        .clk,
        .rst_n_i,
        .flush_i,
        .dispatch_valid_i,
        .dispatch_op_i,
        .dispatch_wreg_id_i,
        .src_data_i,
        .src_tag_i,
        .src_ready_i,
        .entry_ready_o,
        .cdb_valid_i,
        .cdb_reg_id_i,
        .cdb_data_i,
        .wkup_valid_i,
        .wkup_reg_id_i,
        .wkup_data_i,
        .fifo_ready_i,
        .entry_valid_o,
        .result_data_o,
        .result_reg_id_o
    );

endmodule

// ==== verification/mdu_tb_model.svh ====
`ifndef MDU_TB_MODEL_SVH
`define MDU_TB_MODEL_SVH

// --------------------
// producer side with the value of every tag and its busy flag
word_t   tag_val  [32];
bit      tag_busy [32];
rob_id_t wait_q [$];
rob_id_t wk_tag  [WKUP_COUNT];
bit      wk_pend [WKUP_COUNT];

// --------------------
// results still owed by the DUT in dispatch order
word_t   exp_data_q [$];
rob_id_t exp_tag_q [$];

// grab a free source tag from a random starting slot
function automatic bit take_tag(output rob_id_t t);
    int base;
    base = $urandom_range(31);
    for (int n = 0; n < 32; n++) begin
        t = rob_id_t'(base + n);
        if (!tag_busy[t]) begin
            tag_busy[t] = 1'b1;
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// unsigned mul/div rules with the zero-divisor results
function automatic word_t expected_result(mdu_op_t op, word_t a, word_t b);
    logic [63:0] full;
    full = 64'(a) * 64'(b);
    if (op == mdu_mul) begin
        return full[31:0];
    end else if (op == mdu_mulhu) begin
        return full[63:32];
    end else if (b == 32'd0) begin
        return (op == mdu_divu) ? 32'hffff_ffff : a;
    end
    return (op == mdu_divu) ? a / b : a % b;
endfunction

function automatic void push_expected(mdu_op_t op, word_t a, word_t b, rob_id_t dst);
    exp_data_q.push_back(expected_result(op, a, b));
    exp_tag_q.push_back(dst);
endfunction

function automatic void drop_expected();
    exp_data_q.delete();
    exp_tag_q.delete();
endfunction

`endif

// ==== verification/mdu_tb.sv ====
`timescale 1ns/1ps

module mdu_tb;
    import mdu_pkg::*;

    localparam int IQ_SIZE    = 4;
    localparam int CDB_COUNT  = 2;
    localparam int WKUP_COUNT = 2;
    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 18200;
    localparam int TOTAL_OPS  = 260;
    localparam int DIV_CYCLES = 34;
    // per op budget of divider latency plus room for stalls
    localparam longint WATCHDOG_NS = longint'(TOTAL_OPS) * (DIV_CYCLES + 16) * 2 * CLK_PERIOD;

    logic                             clk;
    logic                             rst_n;
    logic                             flush;
    logic             [1:0]           dispatch_valid;
    mdu_op_t          [1:0]           dispatch_op;
    rob_id_t          [1:0]           dispatch_wreg_id;
    word_t            [1:0][1:0]      src_data;
    rob_id_t          [1:0][1:0]      src_tag;
    logic             [1:0][1:0]      src_ready;
    logic                             entry_ready;
    logic             [CDB_COUNT-1:0] cdb_valid;
    rob_id_t          [CDB_COUNT-1:0] cdb_reg_id;
    word_t            [CDB_COUNT-1:0] cdb_data;
    logic            [WKUP_COUNT-1:0] wkup_valid;
    rob_id_t         [WKUP_COUNT-1:0] wkup_reg_id;
    word_t           [WKUP_COUNT-1:0] wkup_data;
    logic                             fifo_ready;
    logic                             entry_valid;
    word_t                            result_data;
    rob_id_t                          result_reg_id;

    // knobs of the running phase
    int n_left;
    int pend_pct;
    int cdb_pct;
    int stall_pct;
    int zero_pct;

    `include "mdu_tb_model.svh"

    mdu_issue_top #(
        .IQ_SIZE   (IQ_SIZE),
        .CDB_COUNT (CDB_COUNT),
        .WKUP_COUNT(WKUP_COUNT)
    ) dut0 (
        .clk                (clk),
        .rst_n_i            (rst_n),
        .flush_i            (flush),
        .dispatch_valid_i   (dispatch_valid),
        .dispatch_op_i      (dispatch_op),
        .dispatch_wreg_id_i (dispatch_wreg_id),
        .src_data_i         (src_data),
        .src_tag_i          (src_tag),
        .src_ready_i        (src_ready),
        .entry_ready_o      (entry_ready),
        .cdb_valid_i        (cdb_valid),
        .cdb_reg_id_i       (cdb_reg_id),
        .cdb_data_i         (cdb_data),
        .wkup_valid_i       (wkup_valid),
        .wkup_reg_id_i      (wkup_reg_id),
        .wkup_data_i        (wkup_data),
        .fifo_ready_i       (fifo_ready),
        .entry_valid_o      (entry_valid),
        .result_data_o      (result_data),
        .result_reg_id_o    (result_reg_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all results came back");
        $display("Test failed");
        $fatal(1);
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // small values, near all-ones values and full-range values
    function automatic word_t rand_word();
        case ($urandom_range(3))
            0: return word_t'($urandom_range(15));
            1: return ~word_t'($urandom_range(15));
            default: return word_t'($urandom);
        endcase
    endfunction

    task automatic check_result();
        assert (exp_tag_q.size() > 0)
        else fail_run("result handshake with no instruction outstanding");
        assert (result_data == exp_data_q[0] && result_reg_id == exp_tag_q[0])
        else fail_run($sformatf("Mismatch at %0t: got %h tag %0d, expected %h tag %0d",
                                $time, result_data, result_reg_id,
                                exp_data_q[0], exp_tag_q[0]));
        void'(exp_data_q.pop_front());
        void'(exp_tag_q.pop_front());
    endtask

    task automatic dispatch_slot(input int s, input bit keep);
        mdu_op_t op;
        word_t   v [2];
        rob_id_t t;
        if (zero_pct > 0) begin
            op = mdu_op_t'(2 + $urandom_range(1));
        end else begin
            op = mdu_op_t'($urandom_range(3));
        end
        dispatch_valid[s]   = 1'b1;
        dispatch_op[s]      = op;
        dispatch_wreg_id[s] = rob_id_t'($urandom);
        for (int k = 0; k < 2; k++) begin
            v[k] = rand_word();
            if (k == 1 && $urandom_range(99) < zero_pct) begin
                v[k] = '0;
            end
            src_ready[s][k] = 1'b1;
            src_data[s][k]  = v[k];
            // pending operand keeps its value on a tag released later
            if ($urandom_range(99) < pend_pct && take_tag(t)) begin
                tag_val[t]      = v[k];
                src_ready[s][k] = 1'b0;
                src_data[s][k]  = word_t'($urandom);
                src_tag[s][k]   = t;
                wait_q.push_back(t);
            end
        end
        if (keep) begin
            push_expected(op, v[0], v[1], dispatch_wreg_id[s]);
        end
        n_left--;
    endtask

    task automatic release_tags();
        int      idx;
        rob_id_t t;
        for (int j = 0; j < CDB_COUNT; j++) begin
            cdb_valid[j]  = 1'b0;
            cdb_reg_id[j] = rob_id_t'($urandom);
            cdb_data[j]   = word_t'($urandom);
            if (wait_q.size() > 0 && $urandom_range(199) < cdb_pct) begin
                idx = $urandom_range(wait_q.size() - 1);
                t   = wait_q[idx];
                wait_q.delete(idx);
                cdb_valid[j]  = 1'b1;
                cdb_reg_id[j] = t;
                cdb_data[j]   = tag_val[t];
                tag_busy[t]   = 1'b0;
            end
        end
        for (int j = 0; j < WKUP_COUNT; j++) begin
            wkup_valid[j]  = 1'b0;
            wkup_reg_id[j] = rob_id_t'($urandom);
            wkup_data[j]   = word_t'($urandom);
            // data follows last cycle's tag on the same port
            if (wk_pend[j]) begin
                wkup_data[j]         = tag_val[wk_tag[j]];
                tag_busy[wk_tag[j]] = 1'b0;
                wk_pend[j]           = 1'b0;
            end
            if (wait_q.size() > 0 && $urandom_range(199) < 100 - cdb_pct) begin
                idx = $urandom_range(wait_q.size() - 1);
                t   = wait_q[idx];
                wait_q.delete(idx);
                wkup_valid[j]  = 1'b1;
                wkup_reg_id[j] = t;
                wk_tag[j]      = t;
                wk_pend[j]     = 1'b1;
            end
        end
    endtask

    // --------------------
    // one clock of stimulus, driven on the falling edge
    task automatic run_cycle(input bit do_flush);
        int outstanding;
        @(negedge clk);
        outstanding = exp_tag_q.size();
        // at most two instructions sit outside the queue
        if (outstanding <= IQ_SIZE - 2) begin
            assert (entry_ready)
            else fail_run("entry_ready_o low although at least two slots are free");
        end
        if (outstanding > IQ_SIZE) begin
            assert (!entry_ready)
            else fail_run("entry_ready_o high although fewer than two slots are free");
        end
        flush      = do_flush;
        fifo_ready = !do_flush && ($urandom_range(99) >= stall_pct);
        if (entry_valid && fifo_ready) begin
            check_result();
        end
        dispatch_valid = '0;
        for (int s = 0; s < 2; s++) begin
            dispatch_op[s]      = mdu_op_t'($urandom_range(3));
            dispatch_wreg_id[s] = rob_id_t'($urandom);
            src_data[s]         = {word_t'($urandom), word_t'($urandom)};
            src_tag[s]          = {rob_id_t'($urandom), rob_id_t'($urandom)};
            src_ready[s]        = 2'($urandom);
        end
        if (entry_ready) begin
            for (int s = 0; s < 2; s++) begin
                if (n_left > 0 && $urandom_range(3) != 0) begin
                    // a dispatch in the flush cycle is dropped by the DUT
                    dispatch_slot(s, !do_flush);
                end
            end
        end
        if (do_flush) begin
            drop_expected();
        end
        release_tags();
    endtask

    task automatic run_phase(input int ops, input int pend, input int cdb,
                             input int stall, input int zero, input int flush_at);
        bit flushed;
        n_left    = ops;
        pend_pct  = pend;
        cdb_pct   = cdb;
        stall_pct = stall;
        zero_pct  = zero;
        flushed   = 1'b0;
        while (n_left > 0 || exp_tag_q.size() > 0) begin
            if (!flushed && flush_at >= 0 && ops - n_left >= flush_at) begin
                run_cycle(1'b1);
                flushed = 1'b1;
            end else begin
                run_cycle(1'b0);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n            = 1'b0;
        flush            = 1'b0;
        fifo_ready       = 1'b0;
        dispatch_valid   = '0;
        dispatch_wreg_id = '0;
        src_data         = '0;
        src_tag          = '0;
        src_ready        = '0;
        cdb_valid        = '0;
        cdb_reg_id       = '0;
        cdb_data         = '0;
        wkup_valid       = '0;
        wkup_reg_id      = '0;
        wkup_data        = '0;
        for (int s = 0; s < 2; s++) begin
            dispatch_op[s] = mdu_mul;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (entry_ready && !entry_valid)
        else fail_run("outputs not idle after reset");

        // phases for present operands, CDB, wakeup, zero divisors, stalls and flush
        run_phase(40, 0, 50, 0, 0, -1);
        run_phase(40, 80, 100, 20, 0, -1);
        run_phase(40, 80, 0, 30, 0, -1);
        run_phase(20, 40, 50, 10, 50, -1);
        run_phase(60, 50, 50, 70, 0, -1);
        run_phase(60, 50, 50, 60, 0, 20);

        repeat (4) run_cycle(1'b0);
        assert (exp_tag_q.size() == 0 && !entry_valid)
        else fail_run("results left over after the last phase");
        $display("Test passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verification
src/mdu_pkg.sv
src/iq_entry.sv
src/operand_bypass.sv
src/mdu_unit.sv
src/mdu_iq.sv
src/mdu_issue_top.sv
verification/mdu_tb.sv
